//--- mult18_top.f
+incdir+.
mult18_pkg.sv
mult18_pp_if.sv
booth_decode.sv
wallace_tree.sv
final_adder.sv
mult18_top.sv
mult18_asserts.sv
tb_mult18.sv

//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat mult18_top.f)) mult18_consts.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_mult18: mult18_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mult18 -f mult18_top.f

run: obj_dir/Vtb_mult18
	./obj_dir/Vtb_mult18 | tee /dev/stderr | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tb_mult18.sv
`include "mult18_consts.svh"
`default_nettype none

module tb_mult18;
  timeunit 1ns;
  timeprecision 100ps;
  import mult18_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int N_CORNER = 23;
  localparam int N_RANDOM = 300;
  // the gapped phase can take two cycles per item, the 60 covers drains and the reset test
  localparam int STIM_CYCLES = 2 * RESET_CYCLES + N_CORNER + 3 * N_RANDOM + 60;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

  logic     clk;
  logic     rstn;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  integer   seed = 11046;
  product_t expected [$];
  logic [`MULT18_LATENCY-1:0] valid_hist;
  int value_errors;
  int timing_errors;
  int reset_errors;
  int cycles = 0;

  mult18_top DUT (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic product_t signed_product(input operand_t x, input operand_t y);
    product_t px;
    product_t py;
    px = {{(`MULT18_PROD_W-`MULT18_OP_W){x[`MULT18_OP_W-1]}}, x};
    py = {{(`MULT18_PROD_W-`MULT18_OP_W){y[`MULT18_OP_W-1]}}, y};
    return px * py;
  endfunction

  function automatic operand_t rand_operand();
    logic [31:0] r;
    r = $random(seed);
    return r[`MULT18_OP_W-1:0];
  endfunction

  task automatic drive_item(input operand_t x, input operand_t y);
    @(posedge clk);
    in_valid <= 1'b1;
    a <= x;
    b <= y;
    expected.push_back(signed_product(x, y));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    idle_cycles(1);
    while (expected.size() != 0) begin
      @(posedge clk);
    end
    idle_cycles(2);
  endtask

  // valid_hist lines up each sampled in_valid with the cycle its result is due
  always @(posedge clk) begin
    product_t exp_val;
    if (!rstn) begin
      valid_hist <= '0;
    end else begin
      valid_hist <= {valid_hist[`MULT18_LATENCY-2:0], in_valid};
      assert (out_valid == valid_hist[`MULT18_LATENCY-1]) else begin
        timing_errors++;
        $display("FAILED out_valid: got %h expected %h", out_valid,
                 valid_hist[`MULT18_LATENCY-1]);
      end
      if (out_valid) begin
        assert (expected.size() != 0) else begin
          timing_errors++;
          $display("out_valid was high but no result was expected");
        end
        if (expected.size() != 0) begin
          exp_val = expected.pop_front();
          assert (product == exp_val) else begin
            value_errors++;
            $display("FAILED product: got %h expected %h", product, exp_val);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results still outstanding",
               cycles, expected.size());
      $display("errors: value %0d, timing %0d, reset %0d",
               value_errors, timing_errors, reset_errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    operand_t    r;
    logic [31:0] gap;
    rstn = 1'b0;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      assert (out_valid == 1'b0) else begin
        reset_errors++;
        $display("FAILED out_valid: got %h expected %h", out_valid, 1'b0);
      end
      assert (product == '0) else begin
        reset_errors++;
        $display("FAILED product: got %h expected %h", product, 36'h0);
      end
    end

    drive_item(18'sh20000, 18'sh20000);
    drive_item(18'sh20000, 18'sh1ffff);
    drive_item(18'sh1ffff, 18'sh1ffff);
    drive_item(18'sh1ffff, 18'sh20000);
    drive_item('0, rand_operand());
    drive_item(rand_operand(), '0);
    drive_item('0, 18'sh20000);
    for (int k = 0; k < 4; k++) begin
      r = rand_operand();
      drive_item(18'sh00001, r);
      drive_item(18'sh3ffff, r);
      drive_item(r, 18'sh00001);
      drive_item(r, 18'sh3ffff);
    end
    drain();

    for (int k = 0; k < N_RANDOM; k++) begin
      drive_item(rand_operand(), rand_operand());
    end
    drain();

    for (int k = 0; k < N_RANDOM; k++) begin
      gap = $random(seed);
      if (gap[0]) begin
        idle_cycles(1);
      end
      drive_item(rand_operand(), rand_operand());
    end
    drain();

    // two items are still in the pipe when reset hits, neither may come out
    drive_item(rand_operand(), rand_operand());
    drive_item(rand_operand(), rand_operand());
    @(posedge clk);
    expected.delete();
    in_valid <= 1'b0;
    rstn <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    idle_cycles(6);
    drive_item(rand_operand(), rand_operand());
    drain();

    $display("errors: value %0d, timing %0d, reset %0d",
             value_errors, timing_errors, reset_errors);
    if (value_errors == 0 && timing_errors == 0 && reset_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mult18_asserts.sv
`include "mult18_consts.svh"
`default_nettype none

module mult18_asserts (
  input logic                 clk,
  input logic                 rstn,
  input logic                 in_valid,
  input logic                 out_valid,
  input mult18_pkg::product_t product
);
  timeunit 1ns;
  timeprecision 100ps;

  // a result leaves the pipe a fixed number of cycles after its input, once reset is long gone
  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    $past(rstn, 1) && $past(rstn, 2) && $past(rstn, 3)
      |-> out_valid == $past(in_valid, `MULT18_LATENCY))
    else $error("out_valid does not match in_valid from three cycles earlier");

  a_no_x: assert property (@(posedge clk) out_valid |-> !$isunknown(product))
    else $error("product has unknown bits while out_valid is high");

  a_quiet_in_reset: assert property (@(posedge clk) !rstn |-> !out_valid)
    else $error("out_valid is high while reset is asserted");

endmodule

bind mult18_top mult18_asserts u_asserts (
  .clk       (clk),
  .rstn      (rstn),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .product   (product)
);

`default_nettype wire

//--- mult18_top.sv
`default_nettype none

module mult18_top (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 in_valid,
  input  mult18_pkg::operand_t a,
  input  mult18_pkg::operand_t b,
  output logic                 out_valid,
  output mult18_pkg::product_t product
);
  import mult18_pkg::*;

  logic     cs_valid;
  product_t cs_sum;
  product_t cs_carry;

  mult18_pp_if pp_if ();

  booth_decode u_booth_decode (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp       (pp_if.source)
  );

  wallace_tree u_wallace_tree (
    .clk      (clk),
    .rstn     (rstn),
    .pp       (pp_if.sink),
    .cs_valid (cs_valid),
    .cs_sum   (cs_sum),
    .cs_carry (cs_carry)
  );

  final_adder u_final_adder (
    .clk       (clk),
    .rstn      (rstn),
    .cs_valid  (cs_valid),
    .cs_sum    (cs_sum),
    .cs_carry  (cs_carry),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

`default_nettype wire

//--- final_adder.sv
`default_nettype none

module final_adder (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 cs_valid,
  input  mult18_pkg::product_t cs_sum,
  input  mult18_pkg::product_t cs_carry,
  output logic                 out_valid,
  output mult18_pkg::product_t product
);
  import mult18_pkg::*;

  product_t sum_d;

  // any carry out of bit 35 is dropped, the true product always fits
  assign sum_d = cs_sum + cs_carry;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= cs_valid;
      if (cs_valid) begin
        product <= sum_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- wallace_tree.sv
`include "mult18_consts.svh"
`default_nettype none

module wallace_tree (
  input  logic                 clk,
  input  logic                 rstn,
  mult18_pp_if.sink            pp,
  output logic                 cs_valid,
  output mult18_pkg::product_t cs_sum,
  output mult18_pkg::product_t cs_carry
);
  import mult18_pkg::*;

  product_t w [`MULT18_ROWS];
  product_t corr_w;
  product_t s1 [3];
  product_t c1 [3];
  product_t s2 [2];
  product_t c2 [2];
  product_t s3;
  product_t c3;
  product_t s4;
  product_t c4;
  product_t s5;
  product_t c5;

  // a row of full adders is just these two words
  function automatic product_t csa_sum(input product_t x, input product_t y,
                                       input product_t z);
    return x ^ y ^ z;
  endfunction

  // the majority bit belongs one column up, the shift puts it there
  function automatic product_t csa_carry(input product_t x, input product_t y,
                                         input product_t z);
    return ((x & y) | (x & z) | (y & z)) << 1;
  endfunction

  // row i sits at bit 2i, sign-extended across the full product width
  for (genvar i = 0; i < `MULT18_ROWS; i++) begin : g_place
    assign w[i] = {{(`MULT18_PROD_W-`MULT18_ROW_W){pp.rows[i][`MULT18_ROW_W-1]}},
                   pp.rows[i]} << (2 * i);
  end

  assign corr_w = {{(`MULT18_PROD_W-`MULT18_CORR_W){1'b0}}, pp.corr};

  // level 1 takes the nine rows three at a time
  for (genvar g = 0; g < 3; g++) begin : g_lvl1
    assign s1[g] = csa_sum(w[3*g], w[3*g+1], w[3*g+2]);
    assign c1[g] = csa_carry(w[3*g], w[3*g+1], w[3*g+2]);
  end

  // level 2 pairs up the six level-1 words into two groups of three
  assign s2[0] = csa_sum(s1[0], c1[0], s1[1]);
  assign c2[0] = csa_carry(s1[0], c1[0], s1[1]);
  assign s2[1] = csa_sum(c1[1], s1[2], c1[2]);
  assign c2[1] = csa_carry(c1[1], s1[2], c1[2]);

  // c2[1] waits for level 4
  assign s3 = csa_sum(s2[0], c2[0], s2[1]);
  assign c3 = csa_carry(s2[0], c2[0], s2[1]);

  // level 4 is a 4:2 step, two chained compressors that fold in c2[1] and then corr
  assign s4 = csa_sum(s3, c3, c2[1]);
  assign c4 = csa_carry(s3, c3, c2[1]);
  assign s5 = csa_sum(s4, c4, corr_w);
  assign c5 = csa_carry(s4, c4, corr_w);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cs_valid <= 1'b0;
      cs_sum   <= '0;
      cs_carry <= '0;
    end else begin
      cs_valid <= pp.valid;
      if (pp.valid) begin
        cs_sum   <= s5;
        cs_carry <= c5;
      end
    end
  end

endmodule

`default_nettype wire

//--- booth_decode.sv
`include "mult18_consts.svh"
`default_nettype none

module booth_decode (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 in_valid,
  input  mult18_pkg::operand_t a,
  input  mult18_pkg::operand_t b,
  mult18_pp_if.source          pp
);
  import mult18_pkg::*;

  // b with the implicit zero below its lsb, so window i is b_ext[2i+2:2i]
  logic [`MULT18_OP_W:0] b_ext;
  pp_row_t a_row;
  pp_row_t a_dbl;
  pp_row_t [`MULT18_ROWS-1:0] rows_d;
  corr_row_t corr_d;

  assign b_ext = {b, 1'b0};
  assign a_row = {{(`MULT18_ROW_W-`MULT18_OP_W){a[`MULT18_OP_W-1]}}, a};
  assign a_dbl = {a[`MULT18_OP_W-1], a, 1'b0};

  for (genvar i = 0; i < `MULT18_ROWS; i++) begin : g_digit
    logic [2:0] win;
    logic       one;
    logic       two;
    logic       neg;
    pp_row_t    mag;

    assign win = b_ext[2*i+2 -: 3];

    // digit = -2*win[2] + win[1] + win[0]
    assign one = win[1] ^ win[0];
    assign two = (win[2] & ~win[1] & ~win[0]) | (~win[2] & win[1] & win[0]);

    // 111 is a zero digit, so it must not invert the row
    assign neg = win[2] & ~(win[1] & win[0]);

    assign mag = one ? a_row : (two ? a_dbl : '0);
    assign rows_d[i] = neg ? ~mag : mag;

    assign corr_d[2*i]   = neg;
    assign corr_d[2*i+1] = 1'b0;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pp.valid <= 1'b0;
      pp.rows  <= '0;
      pp.corr  <= '0;
    end else begin
      pp.valid <= in_valid;
      if (in_valid) begin
        pp.rows <= rows_d;
        pp.corr <= corr_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- mult18_pp_if.sv
`include "mult18_consts.svh"
`default_nettype none

interface mult18_pp_if;
  import mult18_pkg::*;

  logic valid;

  // rows[i] carries weight 4**i, the tree does the shifting
  pp_row_t [`MULT18_ROWS-1:0] rows;

  corr_row_t corr;

  // the decoder owns every signal, no ready flows back
  modport source (
    output valid,
    output rows,
    output corr
  );

  modport sink (
    input valid,
    input rows,
    input corr
  );

endinterface

`default_nettype wire

//--- mult18_pkg.sv
`include "mult18_consts.svh"
`default_nettype none

package mult18_pkg;

  // two's-complement operand as seen on the top-level ports
  typedef logic signed [`MULT18_OP_W-1:0] operand_t;

  // one Booth row, already selected and sign-extended
  // negative digits leave the row inverted and the +1 lives in the correction row
  typedef logic signed [`MULT18_ROW_W-1:0] pp_row_t;

  typedef logic [`MULT18_CORR_W-1:0] corr_row_t;

  // full product width, also used for both carry-save words
  typedef logic signed [`MULT18_PROD_W-1:0] product_t;

endpackage

`default_nettype wire

//--- mult18_consts.svh
`ifndef MULT18_CONSTS_SVH
`define MULT18_CONSTS_SVH

// signed operand width on both multiplier inputs
`define MULT18_OP_W 18

// one Booth row holds up to 2A, so it needs two bits over the operand
`define MULT18_ROW_W 20

// radix-4 recoding of an 18-bit operand gives nine digits
`define MULT18_ROWS 9

// bit 2i completes the negation of row i
`define MULT18_CORR_W 18

`define MULT18_PROD_W 36

// decode, tree and final add registers
`define MULT18_LATENCY 3

`endif
